/* include/rp_cfg.svh */
`ifndef RP_CFG_SVH
`define RP_CFG_SVH

// system bus geometry
`define RP_WORD_W        32            // address and data width
`define RP_REGION_W      3             // eight regions
`define RP_REGION_LSB    20            // region field sits at addr[22:20]
`define RP_OFFSET_W      20            // offset inside one region

// housekeeping block
`define RP_HK_ID         32'h5250_0001 // read-only board id
`define RP_HK_ID_OFS     20'h00000
`define RP_HK_LED_OFS    20'h00030
`define RP_LED_W         8

// pwm configuration block, four words from 0x20
`define RP_PWM_OFS_BASE  20'h00020
`define RP_PWM_CH        4
`define RP_PWM_CFG_W     24            // duty in 23:16, dither in 15:0
`define RP_PWM_DUTY_W    8
`define RP_PWM_DITHER_W  16

// pwm timing
`define RP_PWM_CNT_W     8             // period counter width
`define RP_PWM_IDX_W     4             // dither index, 16 periods per frame
`define RP_PWM_PERIOD    (1 << `RP_PWM_CNT_W)

`endif

/* hw/rp_pkg.sv */
`include "rp_cfg.svh"

package rp_pkg;

  // one word on the system bus, used for both address and data
  typedef logic [`RP_WORD_W-1:0] bus_word_t;

  // region select from addr[22:20]
  // only HK and AMS are populated, the rest answer as empty slots
  typedef enum logic [`RP_REGION_W-1:0] {
    HK    = 3'd0,  // housekeeping
    SCOPE = 3'd1,  // empty
    ASG   = 3'd2,  // empty
    DSP   = 3'd3,  // empty
    AMS   = 3'd4,  // pwm configuration
    FREE5 = 3'd5,
    FREE6 = 3'd6,
    FREE7 = 3'd7
  } region_e;

endpackage

/* hw/sys_bus_if.sv */
`timescale 1ns/1ps

// one slave port of the system bus
interface sys_bus_if;
  import rp_pkg::*;

  bus_word_t addr;   // full address, slave decodes its own offset
  bus_word_t wdata;  // write data, full word
  logic      wen;    // single-cycle write strobe
  logic      ren;    // single-cycle read strobe
  bus_word_t rdata;  // valid in the ack cycle of a read
  logic      ack;    // one cycle after the strobe
  logic      err;    // valid with ack only

  // decoder side
  modport master (
    output addr,
    output wdata,
    output wen,
    output ren,
    input  rdata,
    input  ack,
    input  err
  );

  // register block side
  modport slave (
    input  addr,
    input  wdata,
    input  wen,
    input  ren,
    output rdata,
    output ack,
    output err
  );

endinterface

/* hw/sys_bus_decoder.sv */
`timescale 1ns/1ps
`include "rp_cfg.svh"

module sys_bus_decoder (
  input  logic              adc_clk,
  input  logic              rst_i,
  // outside master
  input  rp_pkg::bus_word_t sys_addr_i,
  input  rp_pkg::bus_word_t sys_wdata_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output rp_pkg::bus_word_t sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o,
  // populated slaves
  sys_bus_if.master         hk_bus,
  sys_bus_if.master         pwm_bus
);
  import rp_pkg::*;

  region_e region;     // decoded region of the current address
  logic    empty_hit;  // address falls in an unpopulated slot
  logic    empty_ack;  // registered answer for empty slots

  //////////////////////////////////////////////////////////////////////
  // region decode and strobe steering
  //////////////////////////////////////////////////////////////////////

  assign region    = region_e'(sys_addr_i[`RP_REGION_LSB +: `RP_REGION_W]);
  assign empty_hit = (region != HK) && (region != AMS);

  // address and data fan out to both slaves
  assign hk_bus.addr   = sys_addr_i;
  assign hk_bus.wdata  = sys_wdata_i;
  assign pwm_bus.addr  = sys_addr_i;
  assign pwm_bus.wdata = sys_wdata_i;

  // strobes only reach the addressed slave
  assign hk_bus.wen  = sys_wen_i && (region == HK);
  assign hk_bus.ren  = sys_ren_i && (region == HK);
  assign pwm_bus.wen = sys_wen_i && (region == AMS);
  assign pwm_bus.ren = sys_ren_i && (region == AMS);

  //////////////////////////////////////////////////////////////////////
  // empty slots
  //////////////////////////////////////////////////////////////////////

  // same one-cycle latency as the real slaves
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      empty_ack <= 1'b0;
    end
    else
    begin
      empty_ack <= (sys_wen_i || sys_ren_i) && empty_hit;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response multiplexer
  //////////////////////////////////////////////////////////////////////

  // address is held until ack so the region still selects the source
  always_comb
  begin
    case (region)
      HK:
      begin
        sys_rdata_o = hk_bus.rdata;
        sys_ack_o   = hk_bus.ack;
        sys_err_o   = hk_bus.err;
      end
      AMS:
      begin
        sys_rdata_o = pwm_bus.rdata;
        sys_ack_o   = pwm_bus.ack;
        sys_err_o   = pwm_bus.err;
      end
      default:
      begin
        sys_rdata_o = '0;         // empty slot reads zero
        sys_ack_o   = empty_ack;
        sys_err_o   = 1'b0;       // never an error
      end
    endcase
  end

endmodule

/* hw/hk_regs.sv */
`timescale 1ns/1ps
`include "rp_cfg.svh"

module hk_regs (
  input  logic                 adc_clk,
  input  logic                 rst_i,
  sys_bus_if.slave             bus,
  output logic [`RP_LED_W-1:0] led_o
);
  import rp_pkg::*;

  logic [`RP_OFFSET_W-1:0] ofs;      // offset inside region 0
  logic [`RP_LED_W-1:0]    led_q;
  bus_word_t               rdata_q;
  logic                    ack_q;
  logic                    err_q;

  assign ofs = bus.addr[`RP_OFFSET_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // register access, answered one cycle after the strobe
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      led_q   <= '0;
      rdata_q <= '0;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
    end
    else
    begin
      ack_q   <= bus.wen || bus.ren;
      err_q   <= 1'b0;
      rdata_q <= '0;                  // zero unless a good read
      if (bus.wen)
      begin
        case (ofs)
          `RP_HK_LED_OFS: led_q <= bus.wdata[`RP_LED_W-1:0];
          default:        err_q <= 1'b1;  // id is read-only, rest unmapped
        endcase
      end
      else if (bus.ren)
      begin
        case (ofs)
          `RP_HK_ID_OFS:  rdata_q <= `RP_HK_ID;
          `RP_HK_LED_OFS: rdata_q <= {{(`RP_WORD_W-`RP_LED_W){1'b0}}, led_q};
          default:        err_q   <= 1'b1;
        endcase
      end
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ack   = ack_q;
  assign bus.err   = err_q;
  assign led_o     = led_q;  // straight from the register

endmodule

/* hw/pwm_cfg_regs.sv */
`timescale 1ns/1ps
`include "rp_cfg.svh"

module pwm_cfg_regs (
  input  logic                     adc_clk,
  input  logic                     rst_i,
  sys_bus_if.slave                 bus,
  output logic [`RP_PWM_CFG_W-1:0] cfg_o [`RP_PWM_CH]
);
  import rp_pkg::*;

  localparam int IDX_W = $clog2(`RP_PWM_CH);
  // bytes covered by the word array
  localparam logic [`RP_OFFSET_W-1:0] PWM_SPAN = `RP_OFFSET_W'(`RP_PWM_CH * 4);

  logic [`RP_OFFSET_W-1:0]  ofs;                // offset inside region 4
  logic [`RP_OFFSET_W-1:0]  rel;                // offset from first pwm word
  logic                     hit;                // aligned and inside the array
  logic [IDX_W-1:0]         idx;                // channel number
  logic [`RP_PWM_CFG_W-1:0] cfg_q [`RP_PWM_CH];
  bus_word_t                rdata_q;
  logic                     ack_q;
  logic                     err_q;

  //////////////////////////////////////////////////////////////////////
  // offset decode
  //////////////////////////////////////////////////////////////////////

  assign ofs = bus.addr[`RP_OFFSET_W-1:0];
  assign rel = ofs - `RP_PWM_OFS_BASE;         // wraps high below the base
  assign hit = (rel < PWM_SPAN) && (rel[1:0] == 2'b00);
  assign idx = rel[2 +: IDX_W];

  //////////////////////////////////////////////////////////////////////
  // register access
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < `RP_PWM_CH; i++)
      begin
        cfg_q[i] <= '0;  // all channels start dark
      end
      rdata_q <= '0;
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
    end
    else
    begin
      ack_q   <= bus.wen || bus.ren;
      err_q   <= (bus.wen || bus.ren) && !hit;  // unmapped offset
      rdata_q <= '0;
      if (bus.wen && hit)
      begin
        cfg_q[idx] <= bus.wdata[`RP_PWM_CFG_W-1:0];  // upper byte dropped
      end
      if (bus.ren && hit)
      begin
        rdata_q <= {{(`RP_WORD_W-`RP_PWM_CFG_W){1'b0}}, cfg_q[idx]};
      end
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ack   = ack_q;
  assign bus.err   = err_q;
  assign cfg_o     = cfg_q;

endmodule

/* hw/pwm_gen.sv */
`timescale 1ns/1ps
`include "rp_cfg.svh"

module pwm_gen (
  input  logic                     adc_clk,
  input  logic                     rst_i,
  input  logic [`RP_PWM_CFG_W-1:0] cfg_i,  // duty 23:16, dither 15:0
  output logic                     pwm_o
);

  logic [`RP_PWM_CNT_W-1:0]    cnt;       // position in the 256 cycle period
  logic [`RP_PWM_IDX_W-1:0]    idx;       // period within the 16 period frame
  logic [`RP_PWM_DUTY_W-1:0]   duty_q;    // latched at period start
  logic [`RP_PWM_DITHER_W-1:0] dither_q;
  logic [`RP_PWM_DUTY_W:0]     thr;       // one extra bit for 255 + 1
  logic                        pwm_q;

  // current threshold, duty plus this period's dither bit
  assign thr = {1'b0, duty_q} + (`RP_PWM_DUTY_W+1)'(dither_q[idx]);

  //////////////////////////////////////////////////////////////////////
  // period counter and configuration latch
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      cnt      <= '0;
      idx      <= '0;
      duty_q   <= '0;
      dither_q <= '0;
    end
    else
    begin
      cnt <= cnt + 1'b1;                // wraps at 256
      if (cnt == '0)
      begin
        // new word only takes effect on a period boundary
        duty_q   <= cfg_i[`RP_PWM_CFG_W-1 -: `RP_PWM_DUTY_W];
        dither_q <= cfg_i[`RP_PWM_DITHER_W-1:0];
        idx      <= idx + 1'b1;         // wraps every 16 periods
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // comparator, registered output
  //////////////////////////////////////////////////////////////////////

  // each counter value is visited once per index over a frame
  // so a frame totals 16 * duty plus the ones in dither
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      pwm_q <= 1'b0;
    end
    else
    begin
      pwm_q <= ({1'b0, cnt} < thr);
    end
  end

  assign pwm_o = pwm_q;

endmodule

/* hw/rp_top.sv */
`timescale 1ns/1ps
`include "rp_cfg.svh"

module rp_top (
  input  logic                 adc_clk,
  input  logic                 rst_i,
  // system bus from the outside master
  input  rp_pkg::bus_word_t    sys_addr_i,
  input  rp_pkg::bus_word_t    sys_wdata_i,
  input  logic                 sys_wen_i,
  input  logic                 sys_ren_i,
  output rp_pkg::bus_word_t    sys_rdata_o,
  output logic                 sys_ack_o,
  output logic                 sys_err_o,
  // board pins
  output logic [`RP_LED_W-1:0] led_o,
  output logic [`RP_PWM_CH-1:0] dac_pwm_o   // slow pwm dac
);

  logic [`RP_PWM_CFG_W-1:0] pwm_cfg [`RP_PWM_CH];  // one word per channel

  sys_bus_if hk_bus ();   // region 0
  sys_bus_if pwm_bus ();  // region 4

  //////////////////////////////////////////////////////////////////////
  // bus decode
  //////////////////////////////////////////////////////////////////////

  sys_bus_decoder u_dec (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .hk_bus      (hk_bus.master),
    .pwm_bus     (pwm_bus.master)
  );

  //////////////////////////////////////////////////////////////////////
  // register blocks
  //////////////////////////////////////////////////////////////////////

  hk_regs u_hk (
    .adc_clk (adc_clk),
    .rst_i   (rst_i),
    .bus     (hk_bus.slave),
    .led_o   (led_o)
  );

  pwm_cfg_regs u_pwm_cfg (
    .adc_clk (adc_clk),
    .rst_i   (rst_i),
    .bus     (pwm_bus.slave),
    .cfg_o   (pwm_cfg)
  );

  //////////////////////////////////////////////////////////////////////
  // pwm channels, all on adc_clk
  //////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < `RP_PWM_CH; g++)
  begin : g_pwm
    pwm_gen u_pwm (
      .adc_clk (adc_clk),
      .rst_i   (rst_i),
      .cfg_i   (pwm_cfg[g]),
      .pwm_o   (dac_pwm_o[g])  // straight to the pin
    );
  end

endmodule

/* test/rp_asserts.sv */
`timescale 1ns/1ps

module rp_asserts (
  input logic              adc_clk,
  input logic              rst_i,
  input logic              sys_wen_i,
  input logic              sys_ren_i,
  input rp_pkg::bus_word_t sys_rdata_o,
  input logic              sys_ack_o,
  input logic              sys_err_o
);

  int      fail_cnt = 0;  // read by the testbench
  logic    strobe;

  assign strobe = sys_wen_i || sys_ren_i;

  //////////////////////////////////////////////////////////////////////
  // bus timing, fixed one cycle answer
  //////////////////////////////////////////////////////////////////////

  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
    strobe |=> sys_ack_o)
    else
    begin
      fail_cnt++;
      $error("no ack one cycle after strobe");
    end

  ack_from_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
    sys_ack_o |-> $past(strobe))
    else
    begin
      fail_cnt++;
      $error("ack without a strobe the cycle before");
    end

  ack_single: assert property (@(posedge adc_clk) disable iff (rst_i)
    sys_ack_o |=> !sys_ack_o)
    else
    begin
      fail_cnt++;
      $error("ack held for two cycles");
    end

  // error only in the ack cycle, data zeroed with it
  err_with_ack: assert property (@(posedge adc_clk) disable iff (rst_i)
    sys_err_o |-> sys_ack_o)
    else
    begin
      fail_cnt++;
      $error("err outside an ack cycle");
    end

  err_zero_data: assert property (@(posedge adc_clk) disable iff (rst_i)
    sys_err_o |-> (sys_rdata_o == '0))
    else
    begin
      fail_cnt++;
      $error("nonzero rdata with err");
    end

endmodule

bind rp_top rp_asserts u_asserts (
  .adc_clk     (adc_clk),
  .rst_i       (rst_i),
  .sys_wen_i   (sys_wen_i),
  .sys_ren_i   (sys_ren_i),
  .sys_rdata_o (sys_rdata_o),
  .sys_ack_o   (sys_ack_o),
  .sys_err_o   (sys_err_o)
);

/* test/rp_tb.sv */
`timescale 1ns/1ps
`include "rp_cfg.svh"

module rp_tb;
  import rp_pkg::*;

  // reset frame 4k, ~330 accesses at 2 cycles, 3 pwm rounds of 3 frames
  // comes to about 42k cycles, limit leaves margin
  localparam int MAX_CYCLES = 60000;
  localparam int FRAME      = 16 * `RP_PWM_PERIOD;  // 4096 cycles
  localparam int ACK_LIMIT  = 4;

  logic                     adc_clk;
  logic                     rst_i;
  bus_word_t                sys_addr_i;
  bus_word_t                sys_wdata_i;
  logic                     sys_wen_i;
  logic                     sys_ren_i;
  bus_word_t                sys_rdata_o;
  logic                     sys_ack_o;
  logic                     sys_err_o;
  logic [`RP_LED_W-1:0]     led_o;
  logic [`RP_PWM_CH-1:0]    dac_pwm_o;

  int                       seed;
  int                       cycles;
  int                       high_cnt [`RP_PWM_CH];  // per channel, one frame
  logic [`RP_LED_W-1:0]     led_m;                  // reference model state
  logic [`RP_PWM_CFG_W-1:0] cfg_m [`RP_PWM_CH];

  rp_top dut0 (.*);

  always #10 adc_clk = ~adc_clk;  // 20 ns period

  always @(posedge adc_clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
      fail_run();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic fail_run();
    $display("Verification failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_value(input string name, input bus_word_t exp, input bus_word_t got);
    assert (got === exp)
    else
    begin
      $display("ERROR %s: expected %h, actual %h", name, exp, got);
      fail_run();
    end
  endtask

  function automatic int ones_in(input logic [`RP_PWM_DITHER_W-1:0] bits);
    int n;
    n = 0;
    for (int i = 0; i < `RP_PWM_DITHER_W; i++)
    begin
      if (bits[i])
        n++;
    end
    return n;
  endfunction

  function automatic logic [`RP_OFFSET_W-1:0] pwm_ofs(input int ch);
    return `RP_PWM_OFS_BASE + `RP_OFFSET_W'(4 * ch);  // word per channel
  endfunction

  function automatic bus_word_t make_addr(input region_e region,
                                          input logic [`RP_OFFSET_W-1:0] ofs,
                                          input bus_word_t upper);
    bus_word_t a;
    a = upper;  // bits above the region are ignored
    a[`RP_REGION_LSB +: `RP_REGION_W] = region;
    a[`RP_OFFSET_W-1:0] = ofs;
    return a;
  endfunction

  // expected answer from the region and error rules, updates model state
  task automatic model_access(input logic wr, input bus_word_t addr, input bus_word_t wdata,
                              output logic exp_err, output bus_word_t exp_rdata);
    region_e                 region;
    logic [`RP_OFFSET_W-1:0] ofs;
    int                      ch;
    region    = region_e'(addr[`RP_REGION_LSB +: `RP_REGION_W]);
    ofs       = addr[`RP_OFFSET_W-1:0];
    exp_err   = 1'b0;
    exp_rdata = '0;
    ch        = -1;
    for (int i = 0; i < `RP_PWM_CH; i++)
    begin
      if (ofs == pwm_ofs(i))
        ch = i;
    end
    case (region)
      HK:
      begin
        if (ofs == `RP_HK_LED_OFS && wr)
          led_m = wdata[`RP_LED_W-1:0];
        else if (ofs == `RP_HK_LED_OFS)
          exp_rdata = bus_word_t'(led_m);
        else if (ofs == `RP_HK_ID_OFS && !wr)
          exp_rdata = `RP_HK_ID;
        else
          exp_err = 1'b1;  // unlisted offset or id write
      end
      AMS:
      begin
        if (ch < 0)
          exp_err = 1'b1;
        else if (wr)
          cfg_m[ch] = wdata[`RP_PWM_CFG_W-1:0];  // low 24 bits kept
        else
          exp_rdata = bus_word_t'(cfg_m[ch]);
      end
      default: ;  // empty slot, zero data and no err
    endcase
  endtask

  // one strobe, then wait for the ack
  task automatic bus_access(input logic wr, input bus_word_t addr, input bus_word_t wdata,
                            output bus_word_t rdata, output logic err);
    int waited;
    waited = 0;
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= wdata;
    sys_wen_i   <= wr;
    sys_ren_i   <= !wr;
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;  // single cycle strobe
    sys_ren_i <= 1'b0;
    @(negedge adc_clk);
    while (!sys_ack_o && waited < ACK_LIMIT)
    begin
      @(negedge adc_clk);
      waited++;
    end
    if (!sys_ack_o)
    begin
      $display("bus access to %h got no acknowledge", addr);
      fail_run();
    end
    check_value("ack latency", '0, bus_word_t'(waited));
    rdata = sys_rdata_o;
    err   = sys_err_o;
  endtask

  task automatic check_access(input string name, input logic wr, input bus_word_t addr,
                              input bus_word_t wdata);
    logic      exp_err;
    bus_word_t exp_rdata;
    logic      err;
    bus_word_t rdata;
    model_access(wr, addr, wdata, exp_err, exp_rdata);
    bus_access(wr, addr, wdata, rdata, err);
    check_value({name, " err"}, bus_word_t'(exp_err), bus_word_t'(err));
    if (!wr)
      check_value({name, " rdata"}, exp_rdata, rdata);
    check_value({name, " led"}, bus_word_t'(led_m), bus_word_t'(led_o));
    check_value({name, " bound checks"}, '0, bus_word_t'(dut0.u_asserts.fail_cnt));
  endtask

  task automatic measure_high();
    for (int ch = 0; ch < `RP_PWM_CH; ch++)
      high_cnt[ch] = 0;
    repeat (FRAME)
    begin
      @(negedge adc_clk);
      for (int ch = 0; ch < `RP_PWM_CH; ch++)
      begin
        if (dac_pwm_o[ch])
          high_cnt[ch]++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    bus_word_t               r;
    bus_word_t               wd;
    logic [`RP_OFFSET_W-1:0] ofs;
    adc_clk     = 1'b0;
    rst_i       = 1'b1;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    seed        = 6;
    cycles      = 0;
    led_m       = '0;
    for (int ch = 0; ch < `RP_PWM_CH; ch++)
      cfg_m[ch] = '0;
    repeat (2) @(posedge adc_clk);
    rst_i <= 1'b0;

    // reset state, pins dark for a whole frame
    @(negedge adc_clk);
    check_value("reset ack", '0, bus_word_t'(sys_ack_o));
    check_value("reset err", '0, bus_word_t'(sys_err_o));
    check_value("reset rdata", '0, sys_rdata_o);
    check_value("reset led", '0, bus_word_t'(led_o));
    measure_high();
    for (int ch = 0; ch < `RP_PWM_CH; ch++)
      check_value("reset pwm high count", '0, bus_word_t'(high_cnt[ch]));

    // housekeeping
    check_access("hk id read", 1'b0, make_addr(HK, `RP_HK_ID_OFS, '0), '0);
    check_access("hk id write", 1'b1, make_addr(HK, `RP_HK_ID_OFS, '0), $random(seed));
    repeat (4)
    begin
      check_access("led write", 1'b1, make_addr(HK, `RP_HK_LED_OFS, '0), $random(seed));
      check_access("led read", 1'b0, make_addr(HK, `RP_HK_LED_OFS, '0), '0);
    end

    // pwm words, then offsets nobody decodes
    for (int ch = 0; ch < `RP_PWM_CH; ch++)
      check_access("pwm write", 1'b1, make_addr(AMS, pwm_ofs(ch), '0), $random(seed));
    for (int ch = 0; ch < `RP_PWM_CH; ch++)
      check_access("pwm read", 1'b0, make_addr(AMS, pwm_ofs(ch), '0), '0);
    check_access("hk unmapped", 1'b0, make_addr(HK, 20'h00004, '0), '0);
    check_access("ams unmapped", 1'b1, make_addr(AMS, 20'h00010, '0), $random(seed));
    check_access("ams unaligned", 1'b0, make_addr(AMS, 20'h00022, '0), '0);

    // random traffic over all eight regions
    for (int n = 0; n < 300; n++)
    begin
      r  = $random(seed);
      wd = $random(seed);
      case (r[6:4])
        0:       ofs = `RP_HK_ID_OFS;
        1, 2:    ofs = `RP_HK_LED_OFS;
        3, 4, 5: ofs = pwm_ofs(int'(r[9:8]));
        default: ofs = r[31:12];  // mostly unmapped
      endcase
      check_access("random", r[0], make_addr(region_e'(r[3:1]), ofs, $random(seed)), wd);
    end
    // empty slot writes must have left this alone
    check_access("final led read", 1'b0, make_addr(HK, `RP_HK_LED_OFS, '0), '0);
    for (int ch = 0; ch < `RP_PWM_CH; ch++)
      check_access("final pwm read", 1'b0, make_addr(AMS, pwm_ofs(ch), '0), '0);

    // duty measurement, first round pins duty at 0 and 255
    for (int round = 0; round < 3; round++)
    begin
      for (int ch = 0; ch < `RP_PWM_CH; ch++)
      begin
        wd = $random(seed);
        if (round == 0)
          wd[23:16] = (ch < 2) ? 8'h00 : 8'hFF;
        if (round == 0 && ch == 3)
          wd[15:0] = 16'hFFFF;  // full on every period
        check_access("pwm config", 1'b1, make_addr(AMS, pwm_ofs(ch), '0), wd);
      end
      repeat (2 * FRAME) @(posedge adc_clk);  // new words latched everywhere
      measure_high();
      for (int ch = 0; ch < `RP_PWM_CH; ch++)
        check_value("pwm high count",
                    bus_word_t'(16 * int'(cfg_m[ch][23:16]) + ones_in(cfg_m[ch][15:0])),
                    bus_word_t'(high_cnt[ch]));
    end

    if (dut0.u_asserts.fail_cnt == 0)
    begin
      $display("Verification passed");
      $finish;
    end
    else
    begin
      $display("bound bus checks reported %0d failures", dut0.u_asserts.fail_cnt);
      fail_run();
    end
  end

endmodule

/* rp_ctrl.f */
+incdir+include
hw/rp_pkg.sv
hw/sys_bus_if.sv
hw/sys_bus_decoder.sv
hw/hk_regs.sv
hw/pwm_cfg_regs.sv
hw/pwm_gen.sv
hw/rp_top.sv
test/rp_asserts.sv
test/rp_tb.sv

/* Makefile */
VERILATOR  := verilator
FILELIST   := rp_ctrl.f
TOP        := rp_tb
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Verification passed
COMMON     := --sv --timing --assert -f $(FILELIST) --top-module $(TOP)
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary -j 0 -Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON)

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
